// File: Makefile
SIM      := verilator
TOP      := refill_tb
FILELIST := compile.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+include
design/refill_pkg.sv
design/way_lru.sv
design/refill_tracker.sv
design/refill_arbiter.sv
design/refill_top.sv
verification/refill_tb.sv

// File: design/refill_arbiter.sv
`default_nettype none

module refill_arbiter
    import refill_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              ic_rd_valid_i,
    output logic              ic_rd_ready_o,
    input  addr_u             ic_rd_addr_i,
    input  logic              dc_rd_valid_i,
    output logic              dc_rd_ready_o,
    input  addr_u             dc_rd_addr_i,
    output logic              ic_rsp_valid_o,
    output logic              dc_rsp_valid_o,
    output logic [LINE_W-1:0] rsp_data_o,
    input  logic              store_valid_i,
    output logic              store_ready_o,
    input  logic [ADDR_W-1:0] store_addr_i,
    input  logic [WORD_W-1:0] store_data_i,
    input  store_size_e       store_size_i,
    output logic              mem_rd_valid_o,
    input  logic              mem_rd_ready_i,
    output logic [ADDR_W-1:0] mem_rd_addr_o,
    input  logic              mem_rsp_valid_i,
    input  logic [LINE_W-1:0] mem_rsp_data_i,
    output logic              mem_wr_valid_o,
    input  logic              mem_wr_ready_i,
    output logic [ADDR_W-1:0] mem_wr_addr_o,
    output logic [WORD_W-1:0] mem_wr_data_o,
    output store_size_e       mem_wr_size_o
);

    arb_state_e state_q;
    arb_state_e state_d;
    logic       grant_dc_q;
    logic       prio_dc_q;
    logic       pick_dc;

    assign pick_dc = dc_rd_valid_i && (prio_dc_q || !ic_rd_valid_i);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ARB_IDLE: begin
                // Stores first so that a later refill sees them
                if (store_valid_i) begin
                    state_d = ARB_STORE;
                end else if (ic_rd_valid_i || dc_rd_valid_i) begin
                    state_d = ARB_RD_REQ;
                end
            end
            ARB_STORE: begin
                if (mem_wr_ready_i) begin
                    state_d = ARB_IDLE;
                end
            end
            ARB_RD_REQ: begin
                if (mem_rd_ready_i) begin
                    state_d = ARB_RD_WAIT;
                end
            end
            ARB_RD_WAIT: begin
                if (mem_rsp_valid_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ARB_IDLE;
            grant_dc_q <= 1'b0;
            prio_dc_q  <= 1'b1;
        end else begin
            state_q <= state_d;
            if (state_q == ARB_IDLE) begin
                grant_dc_q <= pick_dc;
            end
            // Other side gets priority next time
            if (state_q == ARB_RD_WAIT && mem_rsp_valid_i) begin
                prio_dc_q <= !grant_dc_q;
            end
        end
    end

    // Trackers hold address until their rd handshake
    assign mem_rd_valid_o = (state_q == ARB_RD_REQ);
    assign mem_rd_addr_o  = grant_dc_q ? dc_rd_addr_i.raw : ic_rd_addr_i.raw;
    assign dc_rd_ready_o  = mem_rd_valid_o && mem_rd_ready_i && grant_dc_q;
    assign ic_rd_ready_o  = mem_rd_valid_o && mem_rd_ready_i && !grant_dc_q;

    assign dc_rsp_valid_o = (state_q == ARB_RD_WAIT) && mem_rsp_valid_i && grant_dc_q;
    assign ic_rsp_valid_o = (state_q == ARB_RD_WAIT) && mem_rsp_valid_i && !grant_dc_q;
    assign rsp_data_o     = mem_rsp_data_i;

    assign mem_wr_valid_o = (state_q == ARB_STORE);
    assign store_ready_o  = mem_wr_valid_o && mem_wr_ready_i;
    assign mem_wr_addr_o  = store_addr_i;
    assign mem_wr_data_o  = store_data_i;
    assign mem_wr_size_o  = store_size_i;

    // Response goes only to a tracker that has already handed off its request
    a_rsp_to_requester: assert property (@(posedge clk_i) disable iff (rst_i)
        !(ic_rsp_valid_o && ic_rd_valid_i) && !(dc_rsp_valid_o && dc_rd_valid_i));

    // Read request holds, with its address, until memory takes it
    a_rd_held: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_rd_valid_o && !mem_rd_ready_i |=> mem_rd_valid_o && $stable(mem_rd_addr_o));

endmodule

`default_nettype wire

// File: design/refill_pkg.sv
`default_nettype none

package refill_pkg;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int LINE_W   = 128;
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    localparam int IC_WAYS = 4;
    localparam int DC_WAYS = 2;
    // Sized for the larger cache
    localparam int WAY_W   = 2;

    // One address word, seen raw or split into line fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } fields;
    } addr_u;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } store_size_e;

    typedef enum logic [1:0] {
        ARB_IDLE    = 2'd0,
        ARB_STORE   = 2'd1,
        ARB_RD_REQ  = 2'd2,
        ARB_RD_WAIT = 2'd3
    } arb_state_e;

endpackage

`default_nettype wire

// File: design/refill_top.sv
`default_nettype none

module refill_top
    import refill_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    // Instruction cache
    input  logic              ic_miss_valid_i,
    output logic              ic_miss_ready_o,
    input  addr_u             ic_miss_addr_i,
    input  logic              ic_hit_valid_i,
    input  logic [WAY_W-1:0]  ic_hit_way_i,
    output logic              ic_fill_valid_o,
    input  logic              ic_fill_ready_i,
    output addr_u             ic_fill_addr_o,
    output logic [WAY_W-1:0]  ic_fill_way_o,
    output logic [LINE_W-1:0] ic_fill_data_o,
    // Data cache
    input  logic              dc_miss_valid_i,
    output logic              dc_miss_ready_o,
    input  addr_u             dc_miss_addr_i,
    input  logic              dc_hit_valid_i,
    input  logic [WAY_W-1:0]  dc_hit_way_i,
    output logic              dc_fill_valid_o,
    input  logic              dc_fill_ready_i,
    output addr_u             dc_fill_addr_o,
    output logic [WAY_W-1:0]  dc_fill_way_o,
    output logic [LINE_W-1:0] dc_fill_data_o,
    input  logic              dc_store_valid_i,
    output logic              dc_store_ready_o,
    input  logic [ADDR_W-1:0] dc_store_addr_i,
    input  logic [WORD_W-1:0] dc_store_data_i,
    input  store_size_e       dc_store_size_i,
    // Main memory
    output logic              mem_rd_valid_o,
    input  logic              mem_rd_ready_i,
    output logic [ADDR_W-1:0] mem_rd_addr_o,
    input  logic              mem_rsp_valid_i,
    input  logic [LINE_W-1:0] mem_rsp_data_i,
    output logic              mem_wr_valid_o,
    input  logic              mem_wr_ready_i,
    output logic [ADDR_W-1:0] mem_wr_addr_o,
    output logic [WORD_W-1:0] mem_wr_data_o,
    output store_size_e       mem_wr_size_o
);

    logic              ic_rd_valid;
    logic              ic_rd_ready;
    addr_u             ic_rd_addr;
    logic              ic_rsp_valid;
    logic              dc_rd_valid;
    logic              dc_rd_ready;
    addr_u             dc_rd_addr;
    logic              dc_rsp_valid;
    logic [LINE_W-1:0] rsp_data;

    refill_tracker #(
        .NUM_WAYS (IC_WAYS)
    ) ic_tracker (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .miss_valid_i (ic_miss_valid_i),
        .miss_ready_o (ic_miss_ready_o),
        .miss_addr_i  (ic_miss_addr_i),
        .hit_valid_i  (ic_hit_valid_i),
        .hit_way_i    (ic_hit_way_i),
        .rd_valid_o   (ic_rd_valid),
        .rd_ready_i   (ic_rd_ready),
        .rd_addr_o    (ic_rd_addr),
        .rsp_valid_i  (ic_rsp_valid),
        .rsp_data_i   (rsp_data),
        .fill_valid_o (ic_fill_valid_o),
        .fill_ready_i (ic_fill_ready_i),
        .fill_addr_o  (ic_fill_addr_o),
        .fill_way_o   (ic_fill_way_o),
        .fill_data_o  (ic_fill_data_o)
    );

    refill_tracker #(
        .NUM_WAYS (DC_WAYS)
    ) dc_tracker (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .miss_valid_i (dc_miss_valid_i),
        .miss_ready_o (dc_miss_ready_o),
        .miss_addr_i  (dc_miss_addr_i),
        .hit_valid_i  (dc_hit_valid_i),
        .hit_way_i    (dc_hit_way_i),
        .rd_valid_o   (dc_rd_valid),
        .rd_ready_i   (dc_rd_ready),
        .rd_addr_o    (dc_rd_addr),
        .rsp_valid_i  (dc_rsp_valid),
        .rsp_data_i   (rsp_data),
        .fill_valid_o (dc_fill_valid_o),
        .fill_ready_i (dc_fill_ready_i),
        .fill_addr_o  (dc_fill_addr_o),
        .fill_way_o   (dc_fill_way_o),
        .fill_data_o  (dc_fill_data_o)
    );

    refill_arbiter arbiter (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .ic_rd_valid_i   (ic_rd_valid),
        .ic_rd_ready_o   (ic_rd_ready),
        .ic_rd_addr_i    (ic_rd_addr),
        .dc_rd_valid_i   (dc_rd_valid),
        .dc_rd_ready_o   (dc_rd_ready),
        .dc_rd_addr_i    (dc_rd_addr),
        .ic_rsp_valid_o  (ic_rsp_valid),
        .dc_rsp_valid_o  (dc_rsp_valid),
        .rsp_data_o      (rsp_data),
        .store_valid_i   (dc_store_valid_i),
        .store_ready_o   (dc_store_ready_o),
        .store_addr_i    (dc_store_addr_i),
        .store_data_i    (dc_store_data_i),
        .store_size_i    (dc_store_size_i),
        .mem_rd_valid_o  (mem_rd_valid_o),
        .mem_rd_ready_i  (mem_rd_ready_i),
        .mem_rd_addr_o   (mem_rd_addr_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .mem_wr_valid_o  (mem_wr_valid_o),
        .mem_wr_ready_i  (mem_wr_ready_i),
        .mem_wr_addr_o   (mem_wr_addr_o),
        .mem_wr_data_o   (mem_wr_data_o),
        .mem_wr_size_o   (mem_wr_size_o)
    );

endmodule

`default_nettype wire

// File: design/refill_tracker.sv
`default_nettype none

module refill_tracker
    import refill_pkg::*;
#(
    parameter int NUM_WAYS = 4
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              miss_valid_i,
    output logic              miss_ready_o,
    input  addr_u             miss_addr_i,
    input  logic              hit_valid_i,
    input  logic [WAY_W-1:0]  hit_way_i,
    output logic              rd_valid_o,
    input  logic              rd_ready_i,
    output addr_u             rd_addr_o,
    input  logic              rsp_valid_i,
    input  logic [LINE_W-1:0] rsp_data_i,
    output logic              fill_valid_o,
    input  logic              fill_ready_i,
    output addr_u             fill_addr_o,
    output logic [WAY_W-1:0]  fill_way_o,
    output logic [LINE_W-1:0] fill_data_o
);

    logic              busy_q;
    logic              rd_valid_q;
    logic              fill_valid_q;
    addr_u             addr_q;
    addr_u             line_addr;
    logic [LINE_W-1:0] data_q;
    logic [WAY_W-1:0]  way_q;
    logic [WAY_W-1:0]  victim_way;
    logic              hit_pend_q;
    logic [WAY_W-1:0]  hit_pend_way_q;
    logic              miss_hs;
    logic              fill_hs;
    logic              defer_hit;
    logic              touch_valid;
    logic [WAY_W-1:0]  touch_way;

    assign miss_ready_o = !busy_q;
    assign miss_hs      = miss_valid_i && !busy_q;
    assign fill_hs      = fill_valid_q && fill_ready_i;

    always_comb begin
        line_addr = miss_addr_i;
        line_addr.fields.offset = '0;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q       <= 1'b0;
            rd_valid_q   <= 1'b0;
            fill_valid_q <= 1'b0;
        end else begin
            if (miss_hs) begin
                busy_q     <= 1'b1;
                rd_valid_q <= 1'b1;
            end
            if (rd_valid_q && rd_ready_i) begin
                rd_valid_q <= 1'b0;
            end
            if (rsp_valid_i) begin
                fill_valid_q <= 1'b1;
            end
            // Freed here, so miss ready rises the cycle after the fill
            if (fill_hs) begin
                fill_valid_q <= 1'b0;
                busy_q       <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss_hs) begin
            addr_q <= line_addr;
        end
        if (rsp_valid_i) begin
            data_q <= rsp_data_i;
            way_q  <= victim_way;
        end
    end

    // Fill touch wins, a colliding hit waits one cycle
    assign defer_hit = hit_valid_i && (fill_hs || hit_pend_q);

    always_comb begin
        touch_valid = hit_valid_i;
        touch_way   = hit_way_i;
        if (fill_hs) begin
            touch_valid = 1'b1;
            touch_way   = way_q;
        end else if (hit_pend_q) begin
            touch_valid = 1'b1;
            touch_way   = hit_pend_way_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hit_pend_q <= 1'b0;
        end else begin
            hit_pend_q <= defer_hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (defer_hit) begin
            hit_pend_way_q <= hit_way_i;
        end
    end

    way_lru #(
        .NUM_WAYS (NUM_WAYS)
    ) lru (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .touch_valid_i (touch_valid),
        .touch_way_i   (touch_way),
        .victim_way_o  (victim_way)
    );

    assign rd_valid_o   = rd_valid_q;
    assign rd_addr_o    = addr_q;
    assign fill_valid_o = fill_valid_q;
    assign fill_addr_o  = addr_q;
    assign fill_way_o   = way_q;
    assign fill_data_o  = data_q;

    a_fill_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        fill_valid_o && !fill_ready_i |=> fill_valid_o && $stable(fill_addr_o)
            && $stable(fill_way_o) && $stable(fill_data_o));

    // Arbiter only routes a response to the tracker waiting for one
    a_rsp_expected: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_i |-> busy_q && !rd_valid_q && !fill_valid_q);

endmodule

`default_nettype wire

// File: design/way_lru.sv
`default_nettype none

module way_lru
    import refill_pkg::*;
#(
    parameter int NUM_WAYS = 4
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             touch_valid_i,
    input  logic [WAY_W-1:0] touch_way_i,
    output logic [WAY_W-1:0] victim_way_o
);

    localparam int PAIRS = NUM_WAYS * (NUM_WAYS - 1) / 2;

    // Bit (i,j), i < j, is set when way i was used after way j
    logic [PAIRS-1:0]    order_q;
    logic [NUM_WAYS-1:0] is_oldest;

    function automatic int pair_idx(int i, int j);
        return i * NUM_WAYS - (i * (i + 1)) / 2 + (j - i - 1);
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            order_q <= '0;
        end else if (touch_valid_i) begin
            for (int i = 0; i < NUM_WAYS; i++) begin
                for (int j = i + 1; j < NUM_WAYS; j++) begin
                    if (i == int'(touch_way_i)) begin
                        order_q[pair_idx(i, j)] <= 1'b1;
                    end else if (j == int'(touch_way_i)) begin
                        order_q[pair_idx(i, j)] <= 1'b0;
                    end
                end
            end
        end
    end

    // A way is oldest when it lost every pairwise comparison
    always_comb begin
        is_oldest = '1;
        for (int i = 0; i < NUM_WAYS; i++) begin
            for (int j = i + 1; j < NUM_WAYS; j++) begin
                if (order_q[pair_idx(i, j)]) begin
                    is_oldest[i] = 1'b0;
                end else begin
                    is_oldest[j] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        victim_way_o = '0;
        for (int k = NUM_WAYS - 1; k >= 0; k--) begin
            if (is_oldest[k]) begin
                victim_way_o = WAY_W'(k);
            end
        end
    end

    // Callers may only touch ways this cache actually has
    a_touch_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
        touch_valid_i |-> int'(touch_way_i) < NUM_WAYS);

endmodule

`default_nettype wire

// File: include/refill_tb_mem.svh
`ifndef REFILL_TB_MEM_SVH
`define REFILL_TB_MEM_SVH

// Memory model state that lives inside the testbench module
localparam int TB_MEM_LINES     = 256;
localparam int TB_MEM_SEED      = 64;
localparam int TB_MEM_MAX_DELAY = 3;
localparam int TB_MEM_RSP_DELAY = 2;

logic [LINE_W-1:0] tb_mem [TB_MEM_LINES];
logic [ADDR_W-1:0] tb_mem_rd_log [$];
logic [ADDR_W-1:0] tb_mem_wr_log [$];
store_size_e       tb_mem_wr_size_log [$];
int                tb_mem_seed;

function automatic int unsigned line_slot(logic [ADDR_W-1:0] addr);
    return (addr >> OFFSET_W) % TB_MEM_LINES;
endfunction

function automatic void init_memory();
    tb_mem_seed = TB_MEM_SEED;
    for (int i = 0; i < TB_MEM_LINES; i++) begin
        for (int w = 0; w < LINE_W / WORD_W; w++) begin
            tb_mem[i][w*WORD_W +: WORD_W] = $random(tb_mem_seed);
        end
    end
endfunction

function automatic logic [LINE_W-1:0] model_line(logic [ADDR_W-1:0] addr);
    return tb_mem[line_slot(addr)];
endfunction

// Little endian byte lanes inside the line
function automatic void merge_store(logic [ADDR_W-1:0] addr, logic [WORD_W-1:0] data,
                                    store_size_e size);
    int unsigned slot;
    int unsigned base;
    int unsigned bytes;
    slot  = line_slot(addr);
    base  = int'(addr[OFFSET_W-1:0]);
    bytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
    for (int b = 0; b < bytes; b++) begin
        if (base + b < LINE_W / 8) begin
            tb_mem[slot][(base + b) * 8 +: 8] = data[b*8 +: 8];
        end
    end
    tb_mem_wr_log.push_back(addr);
    tb_mem_wr_size_log.push_back(size);
endfunction

function automatic int unsigned ready_delay();
    return $unsigned($random(tb_mem_seed)) % (TB_MEM_MAX_DELAY + 1);
endfunction

`endif

// File: verification/refill_tb.sv
`default_nettype none

module refill_tb
    import refill_pkg::*;
;

`include "refill_tb_mem.svh"

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic              clk_i;
    logic              rst_i;
    logic              ic_miss_valid_i;
    logic              ic_miss_ready_o;
    logic              ic_hit_valid_i;
    logic              dc_miss_valid_i;
    logic              dc_miss_ready_o;
    logic              dc_hit_valid_i;
    addr_u             ic_miss_addr_i;
    addr_u             dc_miss_addr_i;
    addr_u             ic_fill_addr_o;
    addr_u             dc_fill_addr_o;
    logic [WAY_W-1:0]  ic_hit_way_i;
    logic [WAY_W-1:0]  dc_hit_way_i;
    logic [WAY_W-1:0]  ic_fill_way_o;
    logic [WAY_W-1:0]  dc_fill_way_o;
    logic              ic_fill_valid_o;
    logic              ic_fill_ready_i;
    logic              dc_fill_valid_o;
    logic              dc_fill_ready_i;
    logic [LINE_W-1:0] ic_fill_data_o;
    logic [LINE_W-1:0] dc_fill_data_o;
    logic [LINE_W-1:0] mem_rsp_data_i;
    logic              dc_store_valid_i;
    logic              dc_store_ready_o;
    logic [ADDR_W-1:0] dc_store_addr_i;
    logic [ADDR_W-1:0] mem_rd_addr_o;
    logic [ADDR_W-1:0] mem_wr_addr_o;
    logic [WORD_W-1:0] dc_store_data_i;
    logic [WORD_W-1:0] mem_wr_data_o;
    store_size_e       dc_store_size_i;
    store_size_e       mem_wr_size_o;
    logic              mem_rd_valid_o;
    logic              mem_rd_ready_i;
    logic              mem_rsp_valid_i;
    logic              mem_wr_valid_o;
    logic              mem_wr_ready_i;

    refill_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_addr(string name, addr_u got, addr_u exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h",
                                     name, got.raw, exp.raw));
        end
    endtask

    task automatic check_line(string name, logic [LINE_W-1:0] got, logic [LINE_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_way(string name, logic [WAY_W-1:0] got, logic [WAY_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_size(string name, store_size_e got, store_size_e exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic addr_u build_addr(logic [TAG_W-1:0] tag, int index, int offset);
        addr_u a;
        a.fields.tag    = tag;
        a.fields.index  = INDEX_W'(index);
        a.fields.offset = OFFSET_W'(offset);
        return a;
    endfunction

    // Memory read port answers a request after a random delay
    initial begin
        logic [ADDR_W-1:0] addr;
        mem_rd_ready_i  = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_data_i  = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (mem_rd_valid_o === 1'b1) begin
                repeat (ready_delay()) begin
                    @(posedge clk_i);
                    #1;
                end
                addr = mem_rd_addr_o;
                mem_rd_ready_i = 1'b1;
                @(posedge clk_i);
                #1;
                mem_rd_ready_i = 1'b0;
                tb_mem_rd_log.push_back(addr);
                repeat (TB_MEM_RSP_DELAY - 1) begin
                    @(posedge clk_i);
                    #1;
                end
                mem_rsp_data_i  = model_line(addr);
                mem_rsp_valid_i = 1'b1;
                @(posedge clk_i);
                #1;
                mem_rsp_valid_i = 1'b0;
            end
        end
    end

    // Memory write port
    initial begin
        mem_wr_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            if (mem_wr_valid_o === 1'b1) begin
                repeat (ready_delay()) begin
                    @(posedge clk_i);
                    #1;
                end
                mem_wr_ready_i = 1'b1;
                merge_store(mem_wr_addr_o, mem_wr_data_o, mem_wr_size_o);
                @(posedge clk_i);
                #1;
                mem_wr_ready_i = 1'b0;
            end
        end
    end

    task automatic apply_reset();
        rst_i = 1'b1;
        ic_fill_ready_i = 1'b1;
        dc_fill_ready_i = 1'b1;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        tb_mem_rd_log.delete();
        tb_mem_wr_log.delete();
        tb_mem_wr_size_log.delete();
        @(negedge clk_i);
        check_flag("ic_miss_ready_o", ic_miss_ready_o, 1'b1);
        check_flag("dc_miss_ready_o", dc_miss_ready_o, 1'b1);
        check_flag("ic_fill_valid_o", ic_fill_valid_o, 1'b0);
        check_flag("dc_fill_valid_o", dc_fill_valid_o, 1'b0);
        check_flag("mem_rd_valid_o", mem_rd_valid_o, 1'b0);
        check_flag("mem_wr_valid_o", mem_wr_valid_o, 1'b0);
        check_flag("dc_store_ready_o", dc_store_ready_o, 1'b0);
        @(posedge clk_i);
        #1;
    endtask

    task automatic issue_miss(bit dc, addr_u a);
        if (dc) begin
            dc_miss_valid_i = 1'b1;
            dc_miss_addr_i  = a;
        end else begin
            ic_miss_valid_i = 1'b1;
            ic_miss_addr_i  = a;
        end
        @(negedge clk_i);
        while (!(dc ? dc_miss_ready_o : ic_miss_ready_o)) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        if (dc) begin
            dc_miss_valid_i = 1'b0;
        end else begin
            ic_miss_valid_i = 1'b0;
        end
    endtask

    task automatic send_store(logic [ADDR_W-1:0] addr, logic [WORD_W-1:0] data,
                              store_size_e size);
        dc_store_valid_i = 1'b1;
        dc_store_addr_i  = addr;
        dc_store_data_i  = data;
        dc_store_size_i  = size;
        @(negedge clk_i);
        while (!dc_store_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        dc_store_valid_i = 1'b0;
    endtask

    task automatic pulse_hit(logic [WAY_W-1:0] way);
        ic_hit_valid_i = 1'b1;
        ic_hit_way_i   = way;
        @(posedge clk_i);
        #1;
        ic_hit_valid_i = 1'b0;
    endtask

    // Waits for a fill on one side and checks it at the falling edge
    task automatic wait_fill(bit dc, addr_u exp_addr, logic [WAY_W-1:0] exp_way,
                             logic [LINE_W-1:0] exp_line);
        @(negedge clk_i);
        while (!(dc ? dc_fill_valid_o : ic_fill_valid_o)) @(negedge clk_i);
        check_addr(dc ? "dc_fill_addr_o" : "ic_fill_addr_o",
                   dc ? dc_fill_addr_o : ic_fill_addr_o, exp_addr);
        check_way(dc ? "dc_fill_way_o" : "ic_fill_way_o",
                  dc ? dc_fill_way_o : ic_fill_way_o, exp_way);
        check_line(dc ? "dc_fill_data_o" : "ic_fill_data_o",
                   dc ? dc_fill_data_o : ic_fill_data_o, exp_line);
        @(posedge clk_i);
        #1;
    endtask

    task automatic hold_check(addr_u a, logic [WAY_W-1:0] way, logic [LINE_W-1:0] line,
                              int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            check_flag("ic_fill_valid_o", ic_fill_valid_o, 1'b1);
            check_flag("ic_miss_ready_o", ic_miss_ready_o, 1'b0);
            check_addr("ic_fill_addr_o", ic_fill_addr_o, a);
            check_way("ic_fill_way_o", ic_fill_way_o, way);
            check_line("ic_fill_data_o", ic_fill_data_o, line);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic single_miss(bit dc);
        addr_u a;
        addr_u line;
        addr_u seen;
        apply_reset();
        a    = build_addr(dc ? 22'h2a5c3 : 22'h01234, 5, 'hb);
        line = build_addr(dc ? 22'h2a5c3 : 22'h01234, 5, 0);
        issue_miss(dc, a);
        wait_fill(dc, line, 0, model_line(line.raw));
        check_count("memory reads", tb_mem_rd_log.size(), 1);
        seen.raw = tb_mem_rd_log[0];
        check_addr("mem_rd_addr_o", seen, line);
    endtask

    task automatic simultaneous_misses();
        addr_u ic_line;
        addr_u dc_line;
        addr_u seen;
        apply_reset();
        ic_line = build_addr(22'h00311, 12, 0);
        dc_line = build_addr(22'h00422, 13, 0);
        ic_miss_valid_i = 1'b1;
        ic_miss_addr_i  = build_addr(22'h00311, 12, 3);
        dc_miss_valid_i = 1'b1;
        dc_miss_addr_i  = build_addr(22'h00422, 13, 8);
        @(negedge clk_i);
        while (!(ic_miss_ready_o && dc_miss_ready_o)) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        ic_miss_valid_i = 1'b0;
        dc_miss_valid_i = 1'b0;
        // Data side goes first after reset
        wait_fill(1, dc_line, 0, model_line(dc_line.raw));
        wait_fill(0, ic_line, 0, model_line(ic_line.raw));
        check_count("memory reads", tb_mem_rd_log.size(), 2);
        seen.raw = tb_mem_rd_log[0];
        check_addr("first mem_rd_addr_o", seen, dc_line);
        seen.raw = tb_mem_rd_log[1];
        check_addr("second mem_rd_addr_o", seen, ic_line);
    endtask

    task automatic store_then_miss();
        addr_u line;
        addr_u seen;
        logic [LINE_W-1:0] merged;
        apply_reset();
        line   = build_addr(22'h01a0f, 30, 0);
        merged = model_line(line.raw);
        merged[4*8 +: 32] = 32'ha5a5_1234;
        merged[9*8 +: 8]  = 8'hc3;
        send_store(line.raw + 4, 32'ha5a5_1234, SIZE_WORD);
        send_store(line.raw + 9, 32'h5a5a_5ac3, SIZE_BYTE);
        check_count("memory writes", tb_mem_wr_log.size(), 2);
        seen.raw = tb_mem_wr_log[0];
        check_addr("first mem_wr_addr_o", seen, build_addr(22'h01a0f, 30, 4));
        check_size("first mem_wr_size_o", tb_mem_wr_size_log[0], SIZE_WORD);
        seen.raw = tb_mem_wr_log[1];
        check_addr("second mem_wr_addr_o", seen, build_addr(22'h01a0f, 30, 9));
        check_size("second mem_wr_size_o", tb_mem_wr_size_log[1], SIZE_BYTE);
        issue_miss(1, build_addr(22'h01a0f, 30, 2));
        wait_fill(1, line, 0, merged);
    endtask

    task automatic ic_lru_order();
        addr_u line;
        apply_reset();
        for (int k = 0; k < IC_WAYS; k++) begin
            line = build_addr(22'h000a5, 8 + k, 0);
            issue_miss(0, build_addr(22'h000a5, 8 + k, k));
            wait_fill(0, line, WAY_W'(k), model_line(line.raw));
        end
        // Oldest to newest is now 1, 2, 0, 3
        pulse_hit(2);
        pulse_hit(0);
        pulse_hit(3);
        line = build_addr(22'h000a5, 20, 0);
        issue_miss(0, line);
        wait_fill(0, line, 1, model_line(line.raw));
    endtask

    task automatic fill_backpressure();
        addr_u ic_line;
        addr_u dc_line;
        apply_reset();
        ic_line = build_addr(22'h03c01, 40, 0);
        dc_line = build_addr(22'h03c02, 41, 0);
        ic_fill_ready_i = 1'b0;
        issue_miss(0, build_addr(22'h03c01, 40, 7));
        wait_fill(0, ic_line, 0, model_line(ic_line.raw));
        hold_check(ic_line, 0, model_line(ic_line.raw), 3);
        issue_miss(1, dc_line);
        wait_fill(1, dc_line, 0, model_line(dc_line.raw));
        hold_check(ic_line, 0, model_line(ic_line.raw), 2);
        ic_fill_ready_i = 1'b1;
        @(posedge clk_i);
        #1;
        @(negedge clk_i);
        check_flag("ic_fill_valid_o", ic_fill_valid_o, 1'b0);
        check_flag("ic_miss_ready_o", ic_miss_ready_o, 1'b1);
    endtask

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        report_failure($sformatf("Timeout: tests did not finish within %0d cycles",
                                 NUM_TESTS * CYCLES_PER_TEST));
    end

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        ic_miss_valid_i = 1'b0;
        ic_miss_addr_i  = '0;
        ic_hit_valid_i  = 1'b0;
        ic_hit_way_i    = '0;
        ic_fill_ready_i = 1'b1;
        dc_miss_valid_i = 1'b0;
        dc_miss_addr_i  = '0;
        dc_hit_valid_i  = 1'b0;
        dc_hit_way_i    = '0;
        dc_fill_ready_i = 1'b1;
        dc_store_valid_i = 1'b0;
        dc_store_addr_i  = '0;
        dc_store_data_i  = '0;
        dc_store_size_i  = SIZE_WORD;
        init_memory();
        single_miss(0);
        single_miss(1);
        simultaneous_misses();
        store_then_miss();
        ic_lru_order();
        fill_backpressure();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire
